/* all.f */
+incdir+common
common/spi_pkg.sv
spi/spi_fifo.sv
spi/spi_reg_decode.sv
spi/spi_shifter.sv
spi/spi_ctrl.sv
hdl/spi_sequencer.sv
hdl/spi_probe_top.sv
dv/spi_probe_sva.sv
dv/spi_probe_tb.sv

/* common/spi_defs.svh */
`ifndef SPI_DEFS_SVH
`define SPI_DEFS_SVH

// Controller register map
`define SPI_ADDR_CONFIG  3'd0
`define SPI_ADDR_TX      3'd1
`define SPI_ADDR_RX      3'd2
`define SPI_ADDR_STATUS  3'd3
`define SPI_ADDR_CONTROL 3'd4

`define SPI_FIFO_DEPTH 8

// Command script length and idle cycles before each step
`define SPI_SEQ_LEN  13
`define SPI_SEQ_PACE 10

`endif

/* common/spi_pkg.sv */
package spi_pkg;

    // Register address on the controller's register port
    typedef logic [2:0] reg_addr_t;

    // Data word carried by register reads and writes
    typedef logic [31:0] bus_data_t;

    // One byte as it moves over the serial lines
    typedef logic [7:0] spi_byte_t;

    // Each sclk half period lasts divisor + 1 system clocks
    typedef logic [7:0] clk_div_t;

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        DONE
    } shift_state_t;

    // PACE waits out the interval, COMMAND strobes and WAIT holds for the done pulse
    typedef enum logic [1:0] {
        PACE,
        COMMAND,
        WAIT,
        FINISHED
    } seq_state_t;

endpackage

/* dv/spi_probe_sva.sv */
`timescale 1ns/1ps

module spi_probe_sva (
    input logic clk_i,
    input logic rst_n_i,
    input logic sclk_i,
    input logic cs_n_i,
    input logic done_i
);

    int         fail_count = 0;
    logic       sclk_q;
    logic [7:0] phase_cnt_q;
    logic [2:0] fall_cnt_q;

    // Length of the current sclk phase, and the falls seen so far in the current byte
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            sclk_q      <= 1'b0;
            phase_cnt_q <= '0;
            fall_cnt_q  <= '0;
        end else begin
            sclk_q <= sclk_i;
            if (sclk_i != sclk_q) begin
                phase_cnt_q <= 8'd1;
            end else if (phase_cnt_q != 8'hFF) begin
                phase_cnt_q <= phase_cnt_q + 8'd1;
            end
            if (sclk_q && !sclk_i) begin
                fall_cnt_q <= fall_cnt_q + 3'd1;
            end
        end
    end

    sclk_high_phase: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(sclk_i) |-> phase_cnt_q == 8'd50)
        else begin
            $error("sclk high phase did not last 50 clocks");
            fail_count++;
        end

    // The low phase before the first rise of a byte is idle time
    sclk_low_phase: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(sclk_i) && (fall_cnt_q != 3'd0) |-> phase_cnt_q == 8'd50)
        else begin
            $error("sclk low phase inside a byte did not last 50 clocks");
            fail_count++;
        end

    sclk_needs_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(sclk_i) || $fell(sclk_i) |-> !cs_n_i)
        else begin
            $error("sclk moved while chip select was inactive");
            fail_count++;
        end

    done_after_cs: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(done_i) |-> cs_n_i)
        else begin
            $error("done rose while chip select was still active");
            fail_count++;
        end

    done_holds: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> done_i)
        else begin
            $error("done dropped after it was raised");
            fail_count++;
        end

    quiet_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        done_i |=> $stable(sclk_i))
        else begin
            $error("sclk toggled after done");
            fail_count++;
        end

endmodule

bind spi_probe_top spi_probe_sva sva_checks (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .sclk_i  (sclk_o),
    .cs_n_i  (cs_n_o),
    .done_i  (done_o)
);

/* dv/spi_probe_tb.sv */
`timescale 1ns/1ps

module spi_probe_tb;
    import spi_pkg::*;

    localparam int WAIT_LIMIT = 20000;

    logic       clk;
    logic       rst_n;
    logic       miso = 1'b0;
    logic [1:0] interrupt;
    logic       sclk, cs_n, mosi, interrupt_out, done;
    spi_byte_t  data;

    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    bit test_ok = 1'b1;
    bit timed_out = 1'b0;

    // Slave model state
    logic [15:0] lfsr_q = 16'd7;
    spi_byte_t   miso_sh;
    spi_byte_t   mosi_byte;
    int          rise_cnt = 0;
    logic        sclk_prev = 1'b0;
    logic        cs_prev = 1'b1;
    spi_byte_t   sent_q[$];
    spi_byte_t   captured_q[$];
    spi_byte_t   mosi_expected [5] = '{8'h0B, 8'h00, 8'h01, 8'h02, 8'h00};

    spi_probe_top uut (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .miso_i      (miso),
        .interrupt_i (interrupt),
        .sclk_o      (sclk),
        .cs_n_o      (cs_n),
        .mosi_o      (mosi),
        .interrupt_o (interrupt_out),
        .data_o      (data),
        .done_o      (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_slave_byte(output spi_byte_t b);
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        sent_q.push_back(b);
    endtask

    // The mode 0 slave captures mosi on rising sclk and moves miso after falling sclk
    always @(negedge clk) begin
        if (rst_n && cs_prev && !cs_n) begin
            draw_slave_byte(miso_sh);
            miso = miso_sh[7];
            rise_cnt = 0;
        end else if (rst_n && !cs_n && !sclk_prev && sclk) begin
            mosi_byte = {mosi_byte[6:0], mosi};
            rise_cnt++;
            if (rise_cnt == 8) begin
                captured_q.push_back(mosi_byte);
                rise_cnt = 0;
            end
        end else if (rst_n && !cs_n && sclk_prev && !sclk) begin
            if (rise_cnt == 0) begin
                draw_slave_byte(miso_sh);
            end else begin
                miso_sh = {miso_sh[6:0], 1'b0};
            end
            miso = miso_sh[7];
        end
        sclk_prev = sclk;
        cs_prev = cs_n;
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %0b, actual %0b", name, expected, actual);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_byte(input string name, input spi_byte_t expected,
                              input spi_byte_t actual);
        assert (actual === expected) else begin
            $display("mismatch %s: expected %02h, actual %02h", name, expected, actual);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("mismatch %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
            test_ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (!test_ok || timed_out) begin
            failed_tests++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
        test_ok = 1'b1;
    endtask

    task automatic wait_for_sclk();
        int n = 0;
        while (!timed_out && !sclk && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && !sclk) begin
            timed_out = 1'b1;
            $display("timeout: sclk never started toggling");
        end
    endtask

    task automatic wait_for_done();
        int n = 0;
        while (!timed_out && !done && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!timed_out && !done) begin
            timed_out = 1'b1;
            $display("timeout: the sequencer never raised done");
        end
    endtask

    task automatic idle_cycles(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
        end
    endtask

    task automatic pulse_interrupt(input logic [1:0] bits, input string name);
        interrupt = bits;
        @(negedge clk);
        check_bit({name, "_high"}, 1'b1, interrupt_out);
        interrupt = 2'b00;
        @(negedge clk);
        check_bit({name, "_low"}, 1'b0, interrupt_out);
    endtask

    initial begin
        rst_n = 1'b0;
        interrupt = 2'b00;
        idle_cycles(5);
        check_bit("reset_cs_n", 1'b1, cs_n);
        check_bit("reset_sclk", 1'b0, sclk);
        check_bit("reset_mosi", 1'b0, mosi);
        check_bit("reset_done", 1'b0, done);
        check_bit("reset_interrupt", 1'b0, interrupt_out);
        check_byte("reset_data", 8'h00, data);
        finish_test("reset_values");
        rst_n = 1'b1;

        wait_for_sclk();
        if (!timed_out) begin
            check_bit("cs_before_sclk", 1'b0, cs_n);
            check_bit("irq_while_busy", 1'b0, interrupt_out);
            pulse_interrupt(2'b01, "irq_line0");
            pulse_interrupt(2'b10, "irq_line1");
        end
        finish_test("interrupt_pulse");

        wait_for_done();
        idle_cycles(300);
        if (!timed_out) begin
            check_count("mosi_count", 5, captured_q.size());
            foreach (mosi_expected[i]) begin
                if (i < captured_q.size()) begin
                    check_byte($sformatf("mosi_byte%0d", i), mosi_expected[i], captured_q[i]);
                end
            end
        end
        finish_test("mosi_bytes");

        if (!timed_out && sent_q.size() < 5) begin
            $display("the slave sent fewer than five bytes");
            errors++;
            test_ok = 1'b0;
        end else if (!timed_out) begin
            check_byte("rx_data", sent_q[4], data);
        end
        finish_test("rx_data");

        if (!timed_out) begin
            check_bit("done_held", 1'b1, done);
            check_bit("cs_released", 1'b1, cs_n);
            check_bit("irq_idle", 1'b1, interrupt_out);
        end
        finish_test("done_idle");

        check_count("assertion_failures", 0, uut.sva_checks.fail_count);
        finish_test("assertions");

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (timed_out || errors != 0 || failed_tests != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST PASSED");
        end
        $finish;
    end

endmodule

/* hdl/spi_probe_top.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_probe_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               miso_i,
    input  logic [1:0]         interrupt_i,
    output logic               sclk_o,
    output logic               cs_n_o,
    output logic               mosi_o,
    output logic               interrupt_o,
    output spi_pkg::spi_byte_t data_o,
    output logic               done_o
);
    import spi_pkg::*;

    logic      write, write_done, read, read_done, ctrl_irq;
    reg_addr_t write_addr, read_addr;
    bus_data_t write_data, read_data;

    spi_sequencer sequencer (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_done_i (write_done),
        .read_done_i  (read_done),
        .write_o      (write),
        .write_addr_o (write_addr),
        .write_data_o (write_data),
        .read_o       (read),
        .read_addr_o  (read_addr),
        .done_o       (done_o)
    );

    spi_ctrl ctrl (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (write),
        .write_addr_i (write_addr),
        .write_data_i (write_data),
        .write_done_o (write_done),
        .read_i       (read),
        .read_addr_i  (read_addr),
        .read_data_o  (read_data),
        .read_done_o  (read_done),
        .sclk_o       (sclk_o),
        .cs_n_o       (cs_n_o),
        .mosi_o       (mosi_o),
        .miso_i       (miso_i),
        .irq_o        (ctrl_irq)
    );

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_o      <= '0;
            interrupt_o <= 1'b0;
        end else begin
            // Keep the most recent byte read back from the RX FIFO
            if (read_done && (read_addr == `SPI_ADDR_RX)) begin
                data_o <= read_data[7:0];
            end
            interrupt_o <= ctrl_irq || (|interrupt_i);
        end
    end

endmodule

/* hdl/spi_sequencer.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_sequencer (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               write_done_i,
    input  logic               read_done_i,
    output logic               write_o,
    output spi_pkg::reg_addr_t write_addr_o,
    output spi_pkg::bus_data_t write_data_o,
    output logic               read_o,
    output spi_pkg::reg_addr_t read_addr_o,
    output logic               done_o
);
    import spi_pkg::*;

    localparam int PACE_W = $clog2(`SPI_SEQ_PACE);

    // Divisor 49, mode 0, MSB first, interrupt enabled
    localparam bus_data_t CONFIG_WORD = (32'd1 << 11) | 32'd49;

    seq_state_t        state_q;
    logic [PACE_W-1:0] pace_q;
    logic [3:0]        step_q;
    logic              step_write;
    reg_addr_t         step_addr;
    bus_data_t         step_data;

    // Address and data follow the step pointer, so they hold while a read is pending
    always_comb begin
        step_write = 1'b1;
        step_addr  = `SPI_ADDR_TX;
        step_data  = '0;
        case (step_q)
            4'd0: begin
                step_addr = `SPI_ADDR_CONFIG;
                step_data = CONFIG_WORD;
            end
            4'd1: begin
                step_addr = `SPI_ADDR_CONTROL;
                step_data = 32'd1;
            end
            4'd2: step_data = 32'h0B;
            4'd3: step_data = 32'h00;
            4'd4: step_data = 32'h01;
            4'd5: step_data = 32'h02;
            4'd6: step_data = 32'h00;
            4'd7, 4'd8, 4'd9, 4'd10, 4'd11: begin
                step_write = 1'b0;
                step_addr  = `SPI_ADDR_RX;
            end
            default: begin
                // Final step drops chip select
                step_addr = `SPI_ADDR_CONTROL;
                step_data = 32'd0;
            end
        endcase
    end

    assign write_o      = (state_q == COMMAND) && step_write;
    assign read_o       = (state_q == COMMAND) && !step_write;
    assign write_addr_o = step_addr;
    assign read_addr_o  = step_addr;
    assign write_data_o = step_data;
    assign done_o       = state_q == FINISHED;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= PACE;
            pace_q  <= '0;
            step_q  <= '0;
        end else begin
            case (state_q)
                PACE: begin
                    if (pace_q == PACE_W'(`SPI_SEQ_PACE - 1)) begin
                        pace_q  <= '0;
                        state_q <= COMMAND;
                    end else begin
                        pace_q <= pace_q + 1'b1;
                    end
                end
                COMMAND: state_q <= WAIT;
                WAIT: begin
                    if (write_done_i || read_done_i) begin
                        if (step_q == 4'(`SPI_SEQ_LEN - 1)) begin
                            state_q <= FINISHED;
                        end else begin
                            step_q  <= step_q + 1'b1;
                            state_q <= PACE;
                        end
                    end
                end
                default: state_q <= FINISHED;
            endcase
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module spi_probe_tb -f all.f -o spi_probe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/spi_probe_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "Simulation ended without a verdict"
    exit 1
fi
exit 0

/* spi/spi_ctrl.sv */
`timescale 1ns/1ps

module spi_ctrl (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               write_i,
    input  spi_pkg::reg_addr_t write_addr_i,
    input  spi_pkg::bus_data_t write_data_i,
    output logic               write_done_o,
    input  logic               read_i,
    input  spi_pkg::reg_addr_t read_addr_i,
    output spi_pkg::bus_data_t read_data_o,
    output logic               read_done_o,
    output logic               sclk_o,
    output logic               cs_n_o,
    output logic               mosi_o,
    input  logic               miso_i,
    output logic               irq_o
);
    import spi_pkg::*;

    logic      tx_push, tx_pop, tx_empty, tx_full;
    logic      rx_push, rx_pop, rx_empty, rx_full;
    spi_byte_t tx_in, tx_out, rx_in, rx_out;
    clk_div_t  div;
    logic      cpol, cpha, lsb_first, irq_en, busy;

    spi_reg_decode decode (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .write_i      (write_i),
        .write_addr_i (write_addr_i),
        .write_data_i (write_data_i),
        .read_i       (read_i),
        .read_addr_i  (read_addr_i),
        .rx_data_i    (rx_out),
        .tx_full_i    (tx_full),
        .tx_empty_i   (tx_empty),
        .rx_full_i    (rx_full),
        .rx_empty_i   (rx_empty),
        .busy_i       (busy),
        .write_done_o (write_done_o),
        .read_done_o  (read_done_o),
        .read_data_o  (read_data_o),
        .tx_push_o    (tx_push),
        .tx_data_o    (tx_in),
        .rx_pop_o     (rx_pop),
        .div_o        (div),
        .cpol_o       (cpol),
        .cpha_o       (cpha),
        .lsb_first_o  (lsb_first),
        .irq_en_o     (irq_en),
        .cs_n_o       (cs_n_o)
    );

    spi_fifo tx_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (tx_push),
        .data_i  (tx_in),
        .pop_i   (tx_pop),
        .data_o  (tx_out),
        .empty_o (tx_empty),
        .full_o  (tx_full)
    );

    spi_fifo rx_fifo (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (rx_push),
        .data_i  (rx_in),
        .pop_i   (rx_pop),
        .data_o  (rx_out),
        .empty_o (rx_empty),
        .full_o  (rx_full)
    );

    spi_shifter shifter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .div_i       (div),
        .cpol_i      (cpol),
        .cpha_i      (cpha),
        .lsb_first_i (lsb_first),
        .irq_en_i    (irq_en),
        .tx_empty_i  (tx_empty),
        .tx_data_i   (tx_out),
        .miso_i      (miso_i),
        .tx_pop_o    (tx_pop),
        .rx_push_o   (rx_push),
        .rx_data_o   (rx_in),
        .busy_o      (busy),
        .sclk_o      (sclk_o),
        .mosi_o      (mosi_o),
        .irq_o       (irq_o)
    );

endmodule

/* spi/spi_fifo.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_fifo (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              push_i,
    input  spi_pkg::spi_byte_t data_i,
    input  logic              pop_i,
    output spi_pkg::spi_byte_t data_o,
    output logic              empty_o,
    output logic              full_o
);
    import spi_pkg::*;

    localparam int AW = $clog2(`SPI_FIFO_DEPTH);

    spi_byte_t     mem [`SPI_FIFO_DEPTH];
    logic [AW:0]   wr_ptr_q;
    logic [AW:0]   rd_ptr_q;
    logic          do_push;
    logic          do_pop;

    // The extra pointer bit tells a full buffer from an empty one
    assign empty_o = wr_ptr_q == rd_ptr_q;
    assign full_o  = (wr_ptr_q[AW] != rd_ptr_q[AW]) && (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Show-ahead: the head entry is always visible
    assign data_o = mem[rd_ptr_q[AW-1:0]];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr_q[AW-1:0]] <= data_i;
        end
    end

endmodule

/* spi/spi_reg_decode.sv */
`timescale 1ns/1ps
`include "spi_defs.svh"

module spi_reg_decode (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               write_i,
    input  spi_pkg::reg_addr_t write_addr_i,
    input  spi_pkg::bus_data_t write_data_i,
    input  logic               read_i,
    input  spi_pkg::reg_addr_t read_addr_i,
    input  spi_pkg::spi_byte_t rx_data_i,
    input  logic               tx_full_i,
    input  logic               tx_empty_i,
    input  logic               rx_full_i,
    input  logic               rx_empty_i,
    input  logic               busy_i,
    output logic               write_done_o,
    output logic               read_done_o,
    output spi_pkg::bus_data_t read_data_o,
    output logic               tx_push_o,
    output spi_pkg::spi_byte_t tx_data_o,
    output logic               rx_pop_o,
    output spi_pkg::clk_div_t  div_o,
    output logic               cpol_o,
    output logic               cpha_o,
    output logic               lsb_first_o,
    output logic               irq_en_o,
    output logic               cs_n_o
);
    import spi_pkg::*;

    logic      cs_q;
    logic      reg_done_q;
    logic      rx_pend_q;
    bus_data_t reg_data_q;
    bus_data_t reply;

    assign tx_push_o = write_i && (write_addr_i == `SPI_ADDR_TX) && !tx_full_i;
    assign tx_data_o = write_data_i[7:0];
    assign cs_n_o    = ~cs_q;

    // An RX read waits here until the shifter has delivered a byte
    assign rx_pop_o    = rx_pend_q && !rx_empty_i;
    assign read_done_o = reg_done_q || rx_pop_o;
    assign read_data_o = rx_pop_o ? {24'b0, rx_data_i} : reg_data_q;

    always_comb begin
        case (read_addr_i)
            `SPI_ADDR_CONFIG:  reply = {20'b0, irq_en_o, lsb_first_o, cpha_o, cpol_o, div_o};
            `SPI_ADDR_STATUS:  reply = {27'b0, busy_i, rx_full_i, rx_empty_i, tx_full_i, tx_empty_i};
            `SPI_ADDR_CONTROL: reply = {31'b0, cs_q};
            default:           reply = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            write_done_o <= 1'b0;
            reg_done_q   <= 1'b0;
            rx_pend_q    <= 1'b0;
            div_o        <= '0;
            cpol_o       <= 1'b0;
            cpha_o       <= 1'b0;
            lsb_first_o  <= 1'b0;
            irq_en_o     <= 1'b0;
            cs_q         <= 1'b0;
        end else begin
            write_done_o <= write_i;
            reg_done_q   <= read_i && (read_addr_i != `SPI_ADDR_RX);

            if (read_i && (read_addr_i == `SPI_ADDR_RX)) begin
                rx_pend_q <= 1'b1;
            end else if (rx_pop_o) begin
                rx_pend_q <= 1'b0;
            end

            if (write_i && (write_addr_i == `SPI_ADDR_CONFIG)) begin
                div_o       <= write_data_i[7:0];
                cpol_o      <= write_data_i[8];
                cpha_o      <= write_data_i[9];
                lsb_first_o <= write_data_i[10];
                irq_en_o    <= write_data_i[11];
            end
            if (write_i && (write_addr_i == `SPI_ADDR_CONTROL)) begin
                cs_q <= write_data_i[0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_i) begin
            reg_data_q <= reply;
        end
    end

endmodule

/* spi/spi_shifter.sv */
`timescale 1ns/1ps

module spi_shifter (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  spi_pkg::clk_div_t  div_i,
    input  logic               cpol_i,
    input  logic               cpha_i,
    input  logic               lsb_first_i,
    input  logic               irq_en_i,
    input  logic               tx_empty_i,
    input  spi_pkg::spi_byte_t tx_data_i,
    input  logic               miso_i,
    output logic               tx_pop_o,
    output logic               rx_push_o,
    output spi_pkg::spi_byte_t rx_data_o,
    output logic               busy_o,
    output logic               sclk_o,
    output logic               mosi_o,
    output logic               irq_o
);
    import spi_pkg::*;

    shift_state_t state_q;
    clk_div_t     half_cnt_q;
    logic [3:0]   edge_cnt_q;
    spi_byte_t    tx_sh_q;
    spi_byte_t    rx_sh_q;
    spi_byte_t    load_byte;
    logic         sclk_q;
    logic         mosi_q;
    logic         half_end;
    logic         sample_edge;
    logic         shift_edge;

    function automatic spi_byte_t reverse(input spi_byte_t b);
        spi_byte_t r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7 - i];
        end
        return r;
    endfunction

    // Both shift registers always work MSB first and LSB-first bytes are mirrored
    assign load_byte = lsb_first_i ? reverse(tx_data_i) : tx_data_i;
    assign rx_data_o = lsb_first_i ? reverse(rx_sh_q) : rx_sh_q;

    // Even edge counts are leading edges; CPHA moves sampling to the trailing ones
    assign half_end    = (state_q == SHIFT) && (half_cnt_q == div_i);
    assign sample_edge = half_end && (~edge_cnt_q[0] ^ cpha_i);
    assign shift_edge  = half_end && !(~edge_cnt_q[0] ^ cpha_i);

    assign tx_pop_o  = (state_q == IDLE) && !tx_empty_i;
    assign rx_push_o = state_q == DONE;
    assign busy_o    = state_q != IDLE;
    assign irq_o     = irq_en_i && tx_empty_i && (state_q == IDLE);
    assign sclk_o    = sclk_q;
    assign mosi_o    = mosi_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            half_cnt_q <= '0;
            edge_cnt_q <= '0;
            sclk_q     <= 1'b0;
            mosi_q     <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    sclk_q     <= cpol_i;
                    half_cnt_q <= '0;
                    edge_cnt_q <= '0;
                    if (!tx_empty_i) begin
                        state_q <= SHIFT;
                        // Mode 0 and 2 put the first bit out before the first edge
                        if (!cpha_i) begin
                            mosi_q <= load_byte[7];
                        end
                    end
                end
                SHIFT: begin
                    if (half_end) begin
                        half_cnt_q <= '0;
                        sclk_q     <= ~sclk_q;
                        edge_cnt_q <= edge_cnt_q + 1'b1;
                        if (shift_edge) begin
                            mosi_q <= tx_sh_q[7];
                        end
                        if (edge_cnt_q == 4'd15) begin
                            state_q <= DONE;
                        end
                    end else begin
                        half_cnt_q <= half_cnt_q + 1'b1;
                    end
                end
                DONE: state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (tx_pop_o) begin
            tx_sh_q <= cpha_i ? load_byte : {load_byte[6:0], 1'b0};
        end else if (shift_edge) begin
            tx_sh_q <= {tx_sh_q[6:0], 1'b0};
        end
        if (sample_edge) begin
            rx_sh_q <= {rx_sh_q[6:0], miso_i};
        end
    end

endmodule
